//--- lrelu_config.sv
`timescale 1ns/10ps

module lrelu_config (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clken,
  input  logic                       cfg_valid,
  input  lrelu_pkg::cfg_beat_t       cfg,
  input  logic                       s_valid,
  input  lrelu_pkg::user_t           s_user,
  output lrelu_pkg::coeff_t          coeff,
  output logic signed [lrelu_pkg::COEF_W-1:0] d_val
);

  lrelu_pkg::cfg_sel_e sel, sel_next;

  logic [lrelu_pkg::PTR_W-1:0] wr_addr, wr_addr_next;
  logic [lrelu_pkg::PTR_W-1:0] wr_last;   // last write address of this sequence
  logic [lrelu_pkg::PTR_W-1:0] rd_ptr;
  logic [lrelu_pkg::PTR_W-1:0] rd_last;   // wrap point for the current data beat

  logic signed [lrelu_pkg::COEF_W-1:0] d_reg;
  logic signed [lrelu_pkg::COEF_W-1:0] a_tab [lrelu_pkg::DEPTH_1X1];
  logic signed [lrelu_pkg::COEF_W-1:0] b_tab [lrelu_pkg::DEPTH_1X1];

  logic cfg_beat;
  logic data_beat;

  assign cfg_beat  = clken && cfg_valid;
  assign data_beat = clken && s_valid;

  // write depth follows the mode sampled on each config beat
  assign wr_last = cfg.is_1x1 ? lrelu_pkg::PTR_W'(lrelu_pkg::DEPTH_1X1 - 1)
                              : lrelu_pkg::PTR_W'(lrelu_pkg::MEMBERS - 1);

  // read wrap follows the tag of the beat
  assign rd_last = s_user.is_1x1 ? lrelu_pkg::PTR_W'(lrelu_pkg::DEPTH_1X1 - 1)
                                 : lrelu_pkg::PTR_W'(lrelu_pkg::MEMBERS - 1);

  // D once, then N words of A, then N words of B
  always_comb begin
    sel_next     = sel;
    wr_addr_next = wr_addr;
    unique case (sel)
      lrelu_pkg::SEL_D: begin
        sel_next     = lrelu_pkg::SEL_A;
        wr_addr_next = '0;
      end
      lrelu_pkg::SEL_A: begin
        if (wr_addr == wr_last) begin
          sel_next     = lrelu_pkg::SEL_B;
          wr_addr_next = '0;
        end else begin
          wr_addr_next = wr_addr + lrelu_pkg::PTR_W'(1);
        end
      end
      lrelu_pkg::SEL_B: begin
        if (wr_addr == wr_last) begin
          sel_next     = lrelu_pkg::SEL_D;  // sequence done
          wr_addr_next = '0;
        end else begin
          wr_addr_next = wr_addr + lrelu_pkg::PTR_W'(1);
        end
      end
      default: begin
        sel_next     = lrelu_pkg::SEL_D;
        wr_addr_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sel     <= lrelu_pkg::SEL_D;
      wr_addr <= '0;
      d_reg   <= '0;
    end else if (cfg_beat) begin
      sel     <= sel_next;
      wr_addr <= wr_addr_next;
      if (sel == lrelu_pkg::SEL_D) d_reg <= cfg.data;
    end
  end

  // coefficient tables
  always_ff @(posedge clk) begin
    if (cfg_beat && sel == lrelu_pkg::SEL_A) a_tab[wr_addr] <= cfg.data;
    if (cfg_beat && sel == lrelu_pkg::SEL_B) b_tab[wr_addr] <= cfg.data;
  end

  // cyclic read pointer, restarted by any config beat
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (cfg_beat) begin
      rd_ptr <= '0;
    end else if (data_beat) begin
      if (rd_ptr >= rd_last) rd_ptr <= '0;  // also catches a stale 1x1 pointer
      else                   rd_ptr <= rd_ptr + lrelu_pkg::PTR_W'(1);
    end
  end

  // presented in the same cycle as the beat
  assign coeff.a = a_tab[rd_ptr];
  assign coeff.b = b_tab[rd_ptr];
  assign d_val   = d_reg;

endmodule

//--- lrelu_datapath.sv
`timescale 1ns/10ps

module lrelu_datapath (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                clken,
  input  logic                                s_valid,
  input  lrelu_pkg::in_vec_t                  s_data,
  input  lrelu_pkg::user_t                    s_user,
  input  lrelu_pkg::coeff_t                   coeff,
  input  logic signed [lrelu_pkg::COEF_W-1:0] d_val,
  output logic                                m_valid,
  output lrelu_pkg::out_vec_t                 m_data,
  output lrelu_pkg::user_t                    m_user
);

  logic             vld_pipe [lrelu_pkg::PIPE_LATENCY];
  lrelu_pkg::user_t usr_pipe [lrelu_pkg::PIPE_LATENCY];

  // valid delay line, same depth as the lanes
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < lrelu_pkg::PIPE_LATENCY; i++) begin
        vld_pipe[i] <= 1'b0;
      end
    end else if (clken) begin
      vld_pipe[0] <= s_valid;
      for (int i = 1; i < lrelu_pkg::PIPE_LATENCY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  // tags follow the valid bits
  always_ff @(posedge clk) begin
    if (clken) begin
      usr_pipe[0] <= s_user;
      for (int i = 1; i < lrelu_pkg::PIPE_LATENCY; i++) begin
        usr_pipe[i] <= usr_pipe[i-1];
      end
    end
  end

  assign m_valid = vld_pipe[lrelu_pkg::PIPE_LATENCY-1];
  assign m_user  = usr_pipe[lrelu_pkg::PIPE_LATENCY-1];

  // one coefficient pair shared by every lane
  for (genvar u = 0; u < lrelu_pkg::UNITS; u++) begin : g_lane
    lrelu_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .clken    (clken),
      .x        (s_data.lane[u]),
      .coeff    (coeff),
      .d_val    (d_val),
      .is_lrelu (s_user.is_lrelu),
      .y        (m_data.lane[u])
    );
  end

endmodule

//--- lrelu_engine.f
lrelu_pkg.sv
lrelu_config.sv
lrelu_lane.sv
lrelu_datapath.sv
lrelu_engine.sv
lrelu_engine_sva.sv
lrelu_engine_tb.sv

//--- lrelu_engine.sv
`timescale 1ns/10ps

module lrelu_engine (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clken,      // global stall when low

  // data in
  input  logic                 s_valid,
  input  lrelu_pkg::in_vec_t   s_data,
  input  lrelu_pkg::user_t     s_user,

  // data out
  output logic                 m_valid,
  output lrelu_pkg::out_vec_t  m_data,
  output lrelu_pkg::user_t     m_user,

  // config stream, valid only
  input  logic                 cfg_valid,
  input  lrelu_pkg::cfg_beat_t cfg
);

  lrelu_pkg::coeff_t                   coeff;
  logic signed [lrelu_pkg::COEF_W-1:0] d_val;

  lrelu_config u_config (
    .clk       (clk),
    .reset     (reset),
    .clken     (clken),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .s_valid   (s_valid),
    .s_user    (s_user),
    .coeff     (coeff),
    .d_val     (d_val)
  );

  lrelu_datapath u_datapath (
    .clk     (clk),
    .reset   (reset),
    .clken   (clken),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_user  (s_user),
    .coeff   (coeff),   // valid in the cycle of the beat
    .d_val   (d_val),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_user  (m_user)
  );

endmodule

//--- lrelu_engine_sva.sv
`timescale 1ns/10ps

module lrelu_engine_sva (
  input logic       clk,
  input logic       reset,
  input logic       clken,
  input logic       s_valid,
  input logic       m_valid,
  input logic [1:0] cfg_sel
);

  // output register clears with reset
  assert property (@(posedge clk) reset |=> !m_valid)
    else $error("m_valid high in the cycle after reset");

  // four enabled edges from accept to m_valid, stalls in between
  assert property (@(posedge clk) disable iff (reset)
                   (clken && s_valid) |-> ##1 clken[->3] ##1 m_valid)
    else $error("accepted beat did not reach m_valid after 4 enabled cycles");

  assert property (@(posedge clk) disable iff (reset)
                   cfg_sel inside {lrelu_pkg::SEL_D, lrelu_pkg::SEL_A, lrelu_pkg::SEL_B})
    else $error("config selector left its legal states");

endmodule

bind lrelu_engine lrelu_engine_sva u_lrelu_engine_sva (
  .clk     (clk),
  .reset   (reset),
  .clken   (clken),
  .s_valid (s_valid),
  .m_valid (m_valid),
  .cfg_sel (u_config.sel)
);

//--- lrelu_engine_tb.sv
`timescale 1ns/10ps

module lrelu_engine_tb;

  localparam int CYCLE_LIMIT = 6000;  // tests need about 1200 cycles

  logic                 clk;
  logic                 reset;
  logic                 clken;
  logic                 s_valid;
  lrelu_pkg::in_vec_t   s_data;
  lrelu_pkg::user_t     s_user;
  logic                 m_valid;
  lrelu_pkg::out_vec_t  m_data;
  lrelu_pkg::user_t     m_user;
  logic                 cfg_valid;
  lrelu_pkg::cfg_beat_t cfg;

  // testbench copy of the config state
  int                  a_mdl [lrelu_pkg::DEPTH_1X1];
  int                  b_mdl [lrelu_pkg::DEPTH_1X1];
  int                  d_mdl;
  int                  ptr_mdl;
  int                  waddr_mdl;
  lrelu_pkg::cfg_sel_e sel_mdl;

  lrelu_pkg::out_vec_t exp_data_q [$];
  lrelu_pkg::user_t    exp_user_q [$];
  lrelu_pkg::out_vec_t exp_vec;
  lrelu_pkg::user_t    exp_usr;

  string cur_test;
  int    cycle_cnt;
  int    clamp_hi_cnt;  // expected outputs pinned at the top
  int    clamp_lo_cnt;

  lrelu_engine u_lrelu_engine (
    .clk       (clk),
    .reset     (reset),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_user    (s_user),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_user    (m_user),
    .cfg_valid (cfg_valid),
    .cfg       (cfg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // scale, bias, leaky relu, offset, shift, clamp
  function automatic int lane_expect(input int x, input int a, input int b,
                                     input int d, input bit lrelu);
    longint p;
    longint q;
    longint r;
    longint top;
    p = ((longint'(x) * longint'(a)) >>> lrelu_pkg::FRAC_BITS) + longint'(b);
    if (lrelu && p < 0)
      q = (p * longint'(lrelu_pkg::LRELU_ALPHA)) >>> lrelu_pkg::FRAC_BITS;
    else
      q = p;
    r   = (q + longint'(d)) >>> lrelu_pkg::OUT_SHIFT;
    top = (longint'(1) << (lrelu_pkg::WORD_OUT_W - 1)) - 1;
    if (r > top)
      r = top;
    else if (r < -top - 1)
      r = -top - 1;
    return int'(r);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  function automatic lrelu_pkg::in_vec_t make_vec(input int lo, input int hi);
    lrelu_pkg::in_vec_t v;
    for (int u = 0; u < lrelu_pkg::UNITS; u++) begin
      v.lane[u] = 16'(rand_range(lo, hi));
    end
    return v;
  endfunction

  // full scale words mixed with random large ones
  function automatic lrelu_pkg::in_vec_t make_extreme_vec();
    lrelu_pkg::in_vec_t v;
    int pick;
    for (int u = 0; u < lrelu_pkg::UNITS; u++) begin
      pick = int'($urandom_range(2));
      if (pick == 0)      v.lane[u] = 16'sh7fff;
      else if (pick == 1) v.lane[u] = 16'sh8000;
      else                v.lane[u] = 16'(rand_range(-32768, 32767));
    end
    return v;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      clken     = 1'b1;
      s_valid   = 1'b0;
      cfg_valid = 1'b0;
    end
  endtask

  task automatic write_cfg_word(input int data, input bit mode);
    int depth;
    depth = mode ? lrelu_pkg::DEPTH_1X1 : lrelu_pkg::MEMBERS;
    @(negedge clk);
    clken      = 1'b1;
    s_valid    = 1'b0;
    cfg_valid  = 1'b1;
    cfg.data   = 16'(data);
    cfg.is_1x1 = mode;
    case (sel_mdl)
      lrelu_pkg::SEL_D: begin
        d_mdl     = data;
        sel_mdl   = lrelu_pkg::SEL_A;
        waddr_mdl = 0;
      end
      lrelu_pkg::SEL_A: begin
        a_mdl[waddr_mdl] = data;
        if (waddr_mdl == depth - 1) begin
          sel_mdl   = lrelu_pkg::SEL_B;
          waddr_mdl = 0;
        end else begin
          waddr_mdl++;
        end
      end
      default: begin
        b_mdl[waddr_mdl] = data;
        if (waddr_mdl == depth - 1) begin
          sel_mdl   = lrelu_pkg::SEL_D;  // back to D
          waddr_mdl = 0;
        end else begin
          waddr_mdl++;
        end
      end
    endcase
    ptr_mdl = 0;  // every config word restarts the read side
  endtask

  task automatic load_config(input bit mode, input int d_span, input int a_span,
                             input int b_span);
    int depth;
    depth = mode ? lrelu_pkg::DEPTH_1X1 : lrelu_pkg::MEMBERS;
    write_cfg_word(rand_range(-d_span, d_span), mode);
    for (int i = 0; i < depth; i++) write_cfg_word(rand_range(-a_span, a_span), mode);
    for (int i = 0; i < depth; i++) write_cfg_word(rand_range(-b_span, b_span), mode);
    idle(1);
  endtask

  // holds the beat until an enabled edge takes it
  task automatic send_beat(input lrelu_pkg::in_vec_t data, input bit lrelu,
                           input bit is_1x1, input int stall_pct);
    bit                  en;
    int                  last;
    int                  y;
    lrelu_pkg::out_vec_t ev;
    lrelu_pkg::user_t    usr;
    usr.is_lrelu = lrelu;
    usr.is_1x1   = is_1x1;
    do begin
      @(negedge clk);
      en        = (int'($urandom_range(99)) >= stall_pct);
      clken     = en;
      cfg_valid = 1'b0;
      s_valid   = 1'b1;
      s_data    = data;
      s_user    = usr;
    end while (!en);
    for (int u = 0; u < lrelu_pkg::UNITS; u++) begin
      y = lane_expect(int'($signed(data.lane[u])), a_mdl[ptr_mdl], b_mdl[ptr_mdl],
                      d_mdl, lrelu);
      if (y == 127)  clamp_hi_cnt++;
      if (y == -128) clamp_lo_cnt++;
      ev.lane[u] = 8'(y);
    end
    exp_data_q.push_back(ev);
    exp_user_q.push_back(usr);
    last = is_1x1 ? lrelu_pkg::DEPTH_1X1 - 1 : lrelu_pkg::MEMBERS - 1;
    if (ptr_mdl == last) ptr_mdl = 0;
    else                 ptr_mdl++;
  endtask

  task automatic drain();
    idle(1);
    while (exp_data_q.size() != 0) idle(1);
    idle(2);
  endtask

  // output side, one beat per enabled edge with m_valid
  always @(posedge clk) begin
    if (reset === 1'b0 && clken === 1'b1 && m_valid === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        $display("output beat appeared in %s with no beat pending", cur_test);
        stop_on_failure();
      end else begin
        exp_vec = exp_data_q.pop_front();
        exp_usr = exp_user_q.pop_front();
        for (int u = 0; u < lrelu_pkg::UNITS; u++) begin
          check_val($sformatf("%s lane %0d", cur_test, u),
                    int'($signed(exp_vec.lane[u])), int'($signed(m_data.lane[u])));
        end
        check_val($sformatf("%s user", cur_test), int'(exp_usr), int'(m_user));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_failure();
    end
  end

  initial begin
    void'($urandom(32'haf17254e));
    reset        = 1'b1;
    clken        = 1'b1;
    s_valid      = 1'b0;
    s_data       = '0;
    s_user       = '0;
    cfg_valid    = 1'b0;
    cfg          = '0;
    cycle_cnt    = 0;
    clamp_hi_cnt = 0;
    clamp_lo_cnt = 0;
    ptr_mdl      = 0;
    waddr_mdl    = 0;
    d_mdl        = 0;
    sel_mdl      = lrelu_pkg::SEL_D;
    cur_test     = "reset";
    repeat (3) @(negedge clk);
    reset = 1'b0;

    cur_test = "idle after reset";
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_val(cur_test, 0, int'(m_valid));
    end

    cur_test = "3x3 plain";
    load_config(1'b0, 200, 300, 500);
    for (int i = 0; i < 100; i++) send_beat(make_vec(-2000, 2000), 1'b0, 1'b0, 0);
    drain();

    cur_test = "3x3 leaky";  // same tables, mostly negative x
    for (int i = 0; i < 100; i++) begin
      if (i % 2 == 0) send_beat(make_vec(-2000, 300), 1'b1, 1'b0, 0);
      else            send_beat(make_vec(-2000, 2000), 1'b1, 1'b0, 0);
    end
    drain();

    cur_test = "1x1 depth 6";
    load_config(1'b1, 200, 300, 500);
    for (int i = 0; i < 120; i++) begin
      send_beat(make_vec(-2000, 2000), 1'(i % 3 == 0), 1'b1, 0);
    end
    drain();

    cur_test = "clken stalls";
    for (int i = 0; i < 150; i++) begin
      send_beat(make_vec(-3000, 3000), 1'($urandom_range(1)), 1'b1, 30);
    end
    drain();

    cur_test     = "saturation";
    clamp_hi_cnt = 0;
    clamp_lo_cnt = 0;
    load_config(1'b0, 30000, 32767, 30000);
    for (int i = 0; i < 60; i++) send_beat(make_extreme_vec(), 1'(i % 2), 1'b0, 0);
    drain();
    check_val("saturation top hit", 1, int'(clamp_hi_cnt > 0));
    check_val("saturation bottom hit", 1, int'(clamp_lo_cnt > 0));

    if (exp_data_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d expected beats never reached the output", exp_data_q.size());
      $display("Result: FAILED");
      $fatal(1, "beats lost in the pipeline");
    end
  end

endmodule

//--- lrelu_lane.sv
`timescale 1ns/10ps

module lrelu_lane (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   clken,
  input  logic signed [lrelu_pkg::WORD_IN_W-1:0] x,
  input  lrelu_pkg::coeff_t                      coeff,
  input  logic signed [lrelu_pkg::COEF_W-1:0]    d_val,
  input  logic                                   is_lrelu,
  output logic signed [lrelu_pkg::WORD_OUT_W-1:0] y
);

  logic signed [lrelu_pkg::COEF_W-1:0] a_in;
  logic signed [lrelu_pkg::COEF_W-1:0] b_in;

  // stage 1
  logic signed [lrelu_pkg::ACC_W-1:0]  prod_s1;
  logic signed [lrelu_pkg::COEF_W-1:0] b_s1;
  logic signed [lrelu_pkg::COEF_W-1:0] d_s1;
  logic                                lrelu_s1;
  // stage 2
  logic signed [lrelu_pkg::ACC_W-1:0]  p_s2;
  logic signed [lrelu_pkg::COEF_W-1:0] d_s2;
  logic                                lrelu_s2;
  // stage 3
  logic signed [lrelu_pkg::ACC_W-1:0]  q_s3;
  logic signed [lrelu_pkg::COEF_W-1:0] d_s3;
  // stage 4, before the output register
  logic signed [lrelu_pkg::ACC_W-1:0]  r_s4;
  logic signed [lrelu_pkg::ACC_W-1:0]  sat_hi, sat_lo;

  assign a_in = coeff.a;
  assign b_in = coeff.b;

  assign sat_hi = (lrelu_pkg::ACC_W'(1) <<< (lrelu_pkg::WORD_OUT_W - 1)) - 1;  // 127
  assign sat_lo = -(lrelu_pkg::ACC_W'(1) <<< (lrelu_pkg::WORD_OUT_W - 1));    // -128

  assign r_s4 = (q_s3 + lrelu_pkg::ACC_W'(d_s3)) >>> lrelu_pkg::OUT_SHIFT;

  // payload stages, d and b travel with their beat
  always_ff @(posedge clk) begin
    if (clken) begin
      prod_s1 <= lrelu_pkg::ACC_W'(x) * lrelu_pkg::ACC_W'(a_in);
      b_s1    <= b_in;
      d_s1    <= d_val;

      p_s2 <= (prod_s1 >>> lrelu_pkg::FRAC_BITS) + lrelu_pkg::ACC_W'(b_s1);
      d_s2 <= d_s1;

      if (lrelu_s2 && p_s2 < 0)
        q_s3 <= (p_s2 * lrelu_pkg::ACC_W'(lrelu_pkg::LRELU_ALPHA)) >>> lrelu_pkg::FRAC_BITS;
      else
        q_s3 <= p_s2;
      d_s3 <= d_s2;
    end
  end

  // flag pipe and output register
  always_ff @(posedge clk) begin
    if (reset) begin
      lrelu_s1 <= 1'b0;
      lrelu_s2 <= 1'b0;
      y        <= '0;
    end else if (clken) begin
      lrelu_s1 <= is_lrelu;
      lrelu_s2 <= lrelu_s1;
      if (r_s4 > sat_hi)      y <= sat_hi[lrelu_pkg::WORD_OUT_W-1:0];
      else if (r_s4 < sat_lo) y <= sat_lo[lrelu_pkg::WORD_OUT_W-1:0];
      else                    y <= r_s4[lrelu_pkg::WORD_OUT_W-1:0];
    end
  end

endmodule

//--- lrelu_pkg.sv
package lrelu_pkg;

  // lane geometry
  localparam int UNITS      = 4;
  localparam int WORD_IN_W  = 16;
  localparam int WORD_OUT_W = 8;

  // arithmetic widths
  localparam int COEF_W    = 16;    // coefficient and config word
  localparam int ACC_W     = 40;    // never overflows for 16b x 16b plus bias
  localparam int FRAC_BITS = 8;     // Q8 for a and alpha
  localparam int OUT_SHIFT = 4;

  // leaky slope, 26/256 ~ 0.1
  localparam int LRELU_ALPHA = 26;

  // coefficient table depths
  localparam int MEMBERS   = 2;            // 3x3 depth
  localparam int DEPTH_1X1 = 3 * MEMBERS;  // 1x1 depth
  localparam int PTR_W     = 3;

  // input to output, enabled cycles
  localparam int PIPE_LATENCY = 4;

  // tag bits riding along with each data beat
  typedef struct packed {
    logic is_lrelu;
    logic is_1x1;
  } user_t;

  typedef struct packed {
    logic [UNITS-1:0][WORD_IN_W-1:0] lane;
  } in_vec_t;

  typedef struct packed {
    logic [UNITS-1:0][WORD_OUT_W-1:0] lane;
  } out_vec_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] a;  // scale, Q8
    logic signed [COEF_W-1:0] b;  // bias
  } coeff_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] data;
    logic                     is_1x1;  // selects write depth
  } cfg_beat_t;

  // config write target, stepped by each config beat
  typedef enum logic [1:0] {
    SEL_D = 2'd0,
    SEL_A = 2'd1,
    SEL_B = 2'd2
  } cfg_sel_e;

endpackage
